// File: lcd_ctrl.f
common/lcd_pkg.sv
lcd_init/lcd_init_rom.sv
lcd_init/lcd_init_seq.sv
logic/lcd_apb_port.sv
logic/lcd_bus_writer.sv
logic/lcd_ctrl.sv
tests/lcd_bus_monitor.sv
tests/lcd_ctrl_tb.sv

// File: Bender.yml
package:
  name: lcd_ctrl

sources:
  - common/lcd_pkg.sv
  - lcd_init/lcd_init_rom.sv
  - lcd_init/lcd_init_seq.sv
  - logic/lcd_apb_port.sv
  - logic/lcd_bus_writer.sv
  - logic/lcd_ctrl.sv
  - target: test
    files:
      - tests/lcd_bus_monitor.sv
      - tests/lcd_ctrl_tb.sv

// File: tests/lcd_ctrl_tb.sv
module lcd_ctrl_tb;

    typedef enum logic [1:0] {ROW_WRITE, ROW_READ, ROW_WAIT} row_kind_t;

    localparam int N_ROWS = 13;

    logic               pclk;
    logic               rst_n;
    logic               psel;
    logic               penable;
    logic               pwrite;
    lcd_pkg::apb_addr_t paddr;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;
    lcd_pkg::lcd_bus_t  lcd;

    string              row_name     [N_ROWS];
    row_kind_t          row_kind     [N_ROWS];
    lcd_pkg::apb_addr_t row_addr     [N_ROWS];
    logic [31:0]        row_wdata    [N_ROWS];
    logic               row_err      [N_ROWS];
    logic [31:0]        row_rdata    [N_ROWS];
    logic               row_has_word [N_ROWS];
    lcd_pkg::lcd_word_t row_word     [N_ROWS];
    int                 n_rows;
    logic [31:0]        lcg_state;
    logic               timed_out;
    int                 pass_cnt;
    int                 fail_cnt;

    lcd_ctrl dut_i (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .lcd     (lcd)
    );

    lcd_bus_monitor mon_i (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pready  (pready),
        .pslverr (pslverr),
        .prdata  (prdata),
        .lcd     (lcd)
    );

    always #2 pclk = ~pclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] draw_host_data();
        lcg_state = lcg_next(lcg_state);
        return lcg_state;
    endfunction

    task automatic add_row(input string name, input row_kind_t kind,
                           input lcd_pkg::apb_addr_t addr, input logic [31:0] wdata,
                           input logic err, input logic [31:0] rdata);
        row_name[n_rows]     = name;
        row_kind[n_rows]     = kind;
        row_addr[n_rows]     = addr;
        row_wdata[n_rows]    = wdata;
        row_err[n_rows]      = err;
        row_rdata[n_rows]    = rdata;
        row_has_word[n_rows] = (kind == ROW_WRITE) && !err;
        // rs follows the register written, db the low half
        row_word[n_rows]     = '{rs: addr == lcd_pkg::REG_DATA, data: wdata[15:0]};
        n_rows++;
    endtask

    task automatic apb_xfer(input string name, input logic wr, input lcd_pkg::apb_addr_t addr,
                            input logic [31:0] data, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge pclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge pclk);
        penable <= 1'b1;
        @(negedge pclk);
        while (!pready && waited < 64) begin  // slot full stretches this
            @(negedge pclk);
            waited++;
        end
        if (!pready) begin
            $display("timeout: no pready within 64 cycles in test %s", name);
            timed_out = 1'b1;
        end
        rdata = prdata;
        @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_for_init(input string name);
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[0] && !timed_out && polls < 2000) begin
            apb_xfer(name, 1'b0, lcd_pkg::REG_STATUS, '0, st);
            polls++;
        end
        if (!st[0] && !timed_out) begin
            $display("timeout: init_done not seen in %0d status reads", polls);
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (!timed_out && mon_i.err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %-16s ok", name);
        end else begin
            fail_cnt++;
            $display("test %-16s failed", name);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        int          errs_before;
        int          waited;
        pclk      = 1'b0;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        n_rows    = 0;
        lcg_state = 32'he0ca_1268;
        timed_out = 1'b0;
        pass_cnt  = 0;
        fail_cnt  = 0;

        add_row("reset_status", ROW_READ, lcd_pkg::REG_STATUS, '0, 1'b0, 32'h0);
        add_row("early_cmd", ROW_WRITE, lcd_pkg::REG_CMD, 32'h0000_002C, 1'b1, '0);
        add_row("early_data", ROW_WRITE, lcd_pkg::REG_DATA, 32'h0000_1234, 1'b1, '0);
        add_row("init_wait", ROW_WAIT, lcd_pkg::REG_STATUS, '0, 1'b0, '0);
        add_row("init_status", ROW_READ, lcd_pkg::REG_STATUS, '0, 1'b0, 32'h1);
        add_row("host_cmd", ROW_WRITE, lcd_pkg::REG_CMD, draw_host_data(), 1'b0, '0);
        add_row("host_data", ROW_WRITE, lcd_pkg::REG_DATA, draw_host_data(), 1'b0, '0);
        add_row("host_data_full", ROW_WRITE, lcd_pkg::REG_DATA, draw_host_data(), 1'b0, '0);
        add_row("host_cmd_full", ROW_WRITE, lcd_pkg::REG_CMD, draw_host_data(), 1'b0, '0);
        add_row("bad_status_wr", ROW_WRITE, lcd_pkg::REG_STATUS, 32'h1, 1'b1, '0);
        add_row("bad_cmd_rd", ROW_READ, lcd_pkg::REG_CMD, '0, 1'b1, '0);
        add_row("bad_unmapped_rd", ROW_READ, 8'h10, '0, 1'b1, '0);
        add_row("bad_unmapped_wr", ROW_WRITE, 8'h0C, 32'h55, 1'b1, '0);

        repeat (3) @(posedge pclk);
        rst_n <= 1'b1;
        @(negedge pclk);
        errs_before = mon_i.err_cnt;
        mon_i.check_bus_idle("reset_bus");
        report_test("reset_bus", errs_before);

        for (int i = 0; i < n_rows && !timed_out; i++) begin
            errs_before = mon_i.err_cnt;
            if (row_kind[i] == ROW_WAIT) begin
                wait_for_init(row_name[i]);
            end else begin
                if (row_has_word[i]) begin
                    mon_i.expect_word(row_name[i], row_word[i]);
                end
                mon_i.expect_apb(row_name[i], row_err[i],
                                 row_kind[i] == ROW_READ && !row_err[i], row_rdata[i]);
                apb_xfer(row_name[i], row_kind[i] == ROW_WRITE, row_addr[i], row_wdata[i], rdata);
            end
            report_test(row_name[i], errs_before);
        end

        waited = 0;
        while (!timed_out && mon_i.pending() != 0 && waited < 500) begin
            @(negedge pclk);
            waited++;
        end
        if (!timed_out && mon_i.pending() != 0) begin
            $display("timeout: %0d expected panel words never appeared", mon_i.pending());
            timed_out = 1'b1;
        end
        repeat (10) @(negedge pclk);  // room for a stray word to show up

        $display("tests passed %0d failed %0d, check errors %0d",
                 pass_cnt, fail_cnt, mon_i.err_cnt);
        if (!timed_out && fail_cnt == 0 && mon_i.err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: tests/lcd_bus_monitor.sv
module lcd_bus_monitor (
    input logic              pclk,
    input logic              rst_n,
    input logic              psel,
    input logic              penable,
    input logic              pwrite,
    input logic              pready,
    input logic              pslverr,
    input logic [31:0]       prdata,
    input lcd_pkg::lcd_bus_t lcd
);

    // each row packs rs, wait_after, data
    localparam logic [17:0] INIT_TBL [18] = '{
        18'h10001, 18'h10011, 18'h0003A, 18'h20055, 18'h00036, 18'h20000,
        18'h0002A, 18'h20000, 18'h20000, 18'h20000, 18'h2000F,
        18'h0002B, 18'h20000, 18'h20000, 18'h20000, 18'h20007,
        18'h00029, 18'h0002C
    };

    int                  err_cnt;
    lcd_pkg::rom_entry_t exp_q [$];
    string               name_q [$];
    logic                apb_armed;
    string               apb_name;
    logic                apb_err;
    logic                apb_chk_rd;
    logic [31:0]         apb_rd;
    logic                prev_wr_n;
    int                  cyc;
    int                  last_rise;
    logic                last_wait;
    string               last_name;

    initial begin
        err_cnt   = 0;
        apb_armed = 1'b0;
        prev_wr_n = 1'b1;
        cyc       = 0;
        last_rise = 0;
        last_wait = 1'b0;
        for (int i = 0; i < 18; i++) begin
            exp_q.push_back(lcd_pkg::rom_entry_t'(INIT_TBL[i]));
            name_q.push_back($sformatf("init_cmd_%0d", i));
        end
        for (int i = 0; i < 128; i++) begin
            exp_q.push_back('{rs: 1'b1, wait_after: 1'b0, data: 16'hFFFF});  // white fill
            name_q.push_back("init_fill");
        end
    end

    task automatic expect_word(input string name, input lcd_pkg::lcd_word_t w);
        exp_q.push_back('{rs: w.rs, wait_after: 1'b0, data: w.data});
        name_q.push_back(name);
    endtask

    task automatic expect_apb(input string name, input logic err, input logic chk_rd,
                              input logic [31:0] rd);
        apb_name   = name;
        apb_err    = err;
        apb_chk_rd = chk_rd;
        apb_rd     = rd;
        apb_armed  = 1'b1;
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_bus_idle(input string name);
        if (lcd.cs_n !== 1'b1 || lcd.wr_n !== 1'b1) begin
            $display("CHECK FAILED %s expected cs_n=1 wr_n=1 actual cs_n=%b wr_n=%b",
                     name, lcd.cs_n, lcd.wr_n);
            err_cnt++;
        end
    endtask

    task automatic check_word(input logic rs, input lcd_pkg::lcd_data_t db);
        lcd_pkg::rom_entry_t e;
        string               n;
        if (last_wait && cyc - last_rise < lcd_pkg::INIT_DELAY_CYCLES) begin
            $display("CHECK FAILED %s expected gap >= %0d actual %0d",
                     last_name, lcd_pkg::INIT_DELAY_CYCLES, cyc - last_rise);
            err_cnt++;
        end
        last_rise = cyc;
        last_wait = 1'b0;
        if (exp_q.size() == 0) begin
            $display("unexpected panel word rs=%b db=%h with nothing left to expect", rs, db);
            err_cnt++;
        end else begin
            e = exp_q.pop_front();
            n = name_q.pop_front();
            last_wait = e.wait_after;
            last_name = n;
            if (rs !== e.rs || db !== e.data) begin
                $display("CHECK FAILED %s expected rs=%b db=%h actual rs=%b db=%h",
                         n, e.rs, e.data, rs, db);
                err_cnt++;
            end
        end
    endtask

    // mid-cycle sampling, all dut outputs settled
    always @(negedge pclk) begin
        if (!rst_n) begin
            prev_wr_n = 1'b1;
        end else begin
            cyc++;
            if (!prev_wr_n && lcd.wr_n) begin
                check_word(lcd.rs, lcd.db);  // panel latched on this rise
            end
            prev_wr_n = lcd.wr_n;
            if (apb_armed && psel && penable && pready) begin
                apb_armed = 1'b0;
                if (pslverr !== apb_err) begin
                    $display("CHECK FAILED %s expected pslverr=%b actual pslverr=%b",
                             apb_name, apb_err, pslverr);
                    err_cnt++;
                end
                if (apb_chk_rd && !pwrite && prdata !== apb_rd) begin
                    $display("CHECK FAILED %s expected prdata=%h actual prdata=%h",
                             apb_name, apb_rd, prdata);
                    err_cnt++;
                end
            end
        end
    end

endmodule

// File: logic/lcd_ctrl.sv
module lcd_ctrl (
    input  logic               pclk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  lcd_pkg::apb_addr_t paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    output lcd_pkg::lcd_bus_t  lcd
);

    lcd_pkg::rom_addr_t  rom_addr;
    lcd_pkg::rom_entry_t rom_entry;
    lcd_pkg::lcd_word_t  init_word;
    logic                init_valid;
    logic                init_ready;
    logic                init_done;
    lcd_pkg::lcd_word_t  host_word;
    logic                host_valid;
    logic                host_ready;

    lcd_init_rom rom_i (
        .pclk      (pclk),
        .rom_addr  (rom_addr),
        .rom_entry (rom_entry)
    );

    lcd_init_seq seq_i (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .rom_addr   (rom_addr),
        .rom_entry  (rom_entry),
        .init_word  (init_word),
        .init_valid (init_valid),
        .init_ready (init_ready),
        .init_done  (init_done)
    );

    lcd_apb_port apb_i (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .init_done  (init_done),
        .host_word  (host_word),
        .host_valid (host_valid),
        .host_ready (host_ready)
    );

    lcd_bus_writer writer_i (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .init_word  (init_word),
        .init_valid (init_valid),
        .init_ready (init_ready),
        .host_word  (host_word),
        .host_valid (host_valid),
        .host_ready (host_ready),
        .lcd        (lcd)
    );

endmodule

// File: logic/lcd_bus_writer.sv
module lcd_bus_writer (
    input  logic               pclk,
    input  logic               rst_n,
    input  lcd_pkg::lcd_word_t init_word,
    input  logic               init_valid,
    output logic               init_ready,
    input  lcd_pkg::lcd_word_t host_word,
    input  logic               host_valid,
    output logic               host_ready,
    output lcd_pkg::lcd_bus_t  lcd
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_LOW,
        WR_HIGH
    } wr_state_t;

    wr_state_t          state;
    lcd_pkg::wr_cnt_t   cnt;
    lcd_pkg::lcd_word_t word_q;
    logic               cs_n_q;
    logic               wr_n_q;
    logic               idle;
    logic               take;

    assign idle = state == WR_IDLE;

    // init stream always wins
    assign init_ready = idle && init_valid;
    assign host_ready = idle && !init_valid;
    assign take       = init_ready || (host_ready && host_valid);

    assign lcd = '{cs_n: cs_n_q, rs: word_q.rs, wr_n: wr_n_q, db: word_q.data};

    always_ff @(posedge pclk) begin
        if (take) begin
            word_q <= init_valid ? init_word : host_word;
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state  <= WR_IDLE;
            cnt    <= '0;
            cs_n_q <= 1'b1;
            wr_n_q <= 1'b1;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (take) begin
                        state  <= WR_LOW;
                        cnt    <= '0;
                        cs_n_q <= 1'b0;
                        wr_n_q <= 1'b0;
                    end
                end
                WR_LOW: begin
                    if (cnt == lcd_pkg::wr_cnt_t'(lcd_pkg::WR_LOW_CYCLES - 1)) begin
                        state  <= WR_HIGH;
                        cnt    <= '0;
                        wr_n_q <= 1'b1;    // panel latches here
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                WR_HIGH: begin
                    if (cnt == lcd_pkg::wr_cnt_t'(lcd_pkg::WR_HIGH_CYCLES - 1)) begin
                        state  <= WR_IDLE;
                        cnt    <= '0;
                        cs_n_q <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;    // hold time
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    a_wr_in_cs: assert property (
        @(posedge pclk) disable iff (!rst_n)
        !lcd.wr_n |-> !lcd.cs_n
    ) else $error("write strobe low with chip select high");

    // rs and db must not move during a selected cycle
    a_bus_stable: assert property (
        @(posedge pclk) disable iff (!rst_n)
        !lcd.cs_n && !$past(lcd.cs_n) |-> $stable({lcd.rs, lcd.db})
    ) else $error("rs/db changed inside a write cycle");

endmodule

// File: logic/lcd_apb_port.sv
module lcd_apb_port (
    input  logic               pclk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  lcd_pkg::apb_addr_t paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    input  logic               init_done,
    output lcd_pkg::lcd_word_t host_word,
    output logic               host_valid,
    input  logic               host_ready
);

    logic               access;
    logic               hit_cmd;
    logic               hit_data;
    logic               hit_status;
    logic               push;        // write to cmd or data
    logic               stat_rd;
    logic               bad;
    logic               load;
    logic [31:0]        status;
    lcd_pkg::lcd_word_t slot_q;
    logic               slot_full_q;

    assign access     = psel && penable;
    assign hit_cmd    = paddr == lcd_pkg::REG_CMD;
    assign hit_data   = paddr == lcd_pkg::REG_DATA;
    assign hit_status = paddr == lcd_pkg::REG_STATUS;

    assign push    = pwrite && (hit_cmd || hit_data);
    assign stat_rd = !pwrite && hit_status;
    // host writes are refused until the panel is initialised
    assign bad     = !(push || stat_rd) || (push && !init_done);
    assign load    = access && push && !bad && !slot_full_q;

    // full slot stretches the access phase
    assign pready  = access && (bad || stat_rd || load);
    assign pslverr = access && bad;

    always_comb begin
        status = '0;
        status[lcd_pkg::STAT_INIT_DONE_BIT] = init_done;
        status[lcd_pkg::STAT_SLOT_FULL_BIT] = slot_full_q;
    end

    assign prdata = (access && stat_rd) ? status : '0;

    assign host_valid = slot_full_q;
    assign host_word  = slot_q;

    always_ff @(posedge pclk) begin
        if (load) begin
            slot_q <= '{rs: hit_data, data: pwdata[15:0]};
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            slot_full_q <= 1'b0;
        end else if (load) begin
            slot_full_q <= 1'b1;
        end else if (host_valid && host_ready) begin
            slot_full_q <= 1'b0;    // writer took it
        end
    end

    // access phase always follows a setup cycle
    a_pready_access: assert property (
        @(posedge pclk) disable iff (!rst_n)
        pready |-> psel && penable && $past(psel)
    ) else $error("pready outside access phase");

endmodule

// File: lcd_init/lcd_init_seq.sv
module lcd_init_seq (
    input  logic                pclk,
    input  logic                rst_n,
    output lcd_pkg::rom_addr_t  rom_addr,
    input  lcd_pkg::rom_entry_t rom_entry,
    output lcd_pkg::lcd_word_t  init_word,
    output logic                init_valid,
    input  logic                init_ready,
    output logic                init_done
);

    typedef enum logic [2:0] {
        SEQ_FETCH,
        SEQ_ISSUE,
        SEQ_DELAY,
        SEQ_FILL,
        SEQ_DONE
    } seq_state_t;

    seq_state_t          state;
    lcd_pkg::rom_addr_t  addr_q;
    logic                tbl_end_q;    // last table word taken
    lcd_pkg::delay_cnt_t delay_cnt;
    lcd_pkg::fill_cnt_t  fill_cnt;
    logic                accept;
    logic                last_entry;

    assign accept     = init_valid && init_ready;
    assign last_entry = addr_q == lcd_pkg::rom_addr_t'(lcd_pkg::INIT_ROM_DEPTH - 1);
    assign rom_addr   = addr_q;
    assign init_valid = (state == SEQ_ISSUE) || (state == SEQ_FILL);

    always_comb begin
        if (state == SEQ_FILL) begin
            init_word = '{rs: 1'b1, data: lcd_pkg::FILL_COLOR};
        end else begin
            init_word = '{rs: rom_entry.rs, data: rom_entry.data};
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state     <= SEQ_FETCH;
            addr_q    <= '0;
            tbl_end_q <= 1'b0;
            delay_cnt <= '0;
            fill_cnt  <= '0;
            init_done <= 1'b0;
        end else begin
            case (state)
                SEQ_FETCH: begin
                    state <= SEQ_ISSUE;    // rom output valid next cycle
                end
                SEQ_ISSUE: begin
                    if (accept) begin
                        // step the address now so the next row is
                        // already read out when a delay ends
                        if (last_entry) begin
                            tbl_end_q <= 1'b1;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                        end
                        delay_cnt <= '0;
                        fill_cnt  <= lcd_pkg::fill_cnt_t'(lcd_pkg::FILL_WORDS - 1);
                        if (rom_entry.wait_after) begin
                            state <= SEQ_DELAY;
                        end else if (last_entry) begin
                            state <= SEQ_FILL;
                        end else begin
                            state <= SEQ_FETCH;
                        end
                    end
                end
                SEQ_DELAY: begin
                    if (delay_cnt == lcd_pkg::delay_cnt_t'(lcd_pkg::INIT_DELAY_CYCLES - 1)) begin
                        state <= tbl_end_q ? SEQ_FILL : SEQ_ISSUE;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                SEQ_FILL: begin
                    if (accept) begin
                        if (fill_cnt == '0) begin
                            state     <= SEQ_DONE;
                            init_done <= 1'b1;
                        end else begin
                            fill_cnt <= fill_cnt - 1'b1;
                        end
                    end
                end
                SEQ_DONE: begin
                    state <= SEQ_DONE;    // host owns the bus from here
                end
                default: begin
                    state <= SEQ_FETCH;
                end
            endcase
        end
    end

    // a word offered to the writer is held until taken
    a_init_hold: assert property (
        @(posedge pclk) disable iff (!rst_n)
        init_valid && !init_ready |=> init_valid && $stable(init_word)
    ) else $error("init word changed before it was accepted");

endmodule

// File: lcd_init/lcd_init_rom.sv
module lcd_init_rom (
    input  logic                pclk,
    input  lcd_pkg::rom_addr_t  rom_addr,
    output lcd_pkg::rom_entry_t rom_entry
);

    // fields are rs, wait_after, data
    always_ff @(posedge pclk) begin
        case (rom_addr)
            5'd0:    rom_entry <= '{1'b0, 1'b1, 16'h0001};  // soft reset
            5'd1:    rom_entry <= '{1'b0, 1'b1, 16'h0011};  // sleep out
            5'd2:    rom_entry <= '{1'b0, 1'b0, 16'h003A};  // pixel format
            5'd3:    rom_entry <= '{1'b1, 1'b0, 16'h0055};  // 16 bpp
            5'd4:    rom_entry <= '{1'b0, 1'b0, 16'h0036};  // memory access ctrl
            5'd5:    rom_entry <= '{1'b1, 1'b0, 16'h0000};
            5'd6:    rom_entry <= '{1'b0, 1'b0, 16'h002A};  // column address
            5'd7:    rom_entry <= '{1'b1, 1'b0, 16'h0000};
            5'd8:    rom_entry <= '{1'b1, 1'b0, 16'h0000};
            5'd9:    rom_entry <= '{1'b1, 1'b0, 16'h0000};
            5'd10:   rom_entry <= '{1'b1, 1'b0, 16'h000F};  // last column 15
            5'd11:   rom_entry <= '{1'b0, 1'b0, 16'h002B};  // row address
            5'd12:   rom_entry <= '{1'b1, 1'b0, 16'h0000};
            5'd13:   rom_entry <= '{1'b1, 1'b0, 16'h0000};
            5'd14:   rom_entry <= '{1'b1, 1'b0, 16'h0000};
            5'd15:   rom_entry <= '{1'b1, 1'b0, 16'h0007};  // last row 7
            5'd16:   rom_entry <= '{1'b0, 1'b0, 16'h0029};  // display on
            5'd17:   rom_entry <= '{1'b0, 1'b0, 16'h002C};  // memory write
            default: rom_entry <= '0;
        endcase
    end

endmodule

// File: common/lcd_pkg.sv
package lcd_pkg;

    // bus and table widths
    typedef logic [15:0] lcd_data_t;
    typedef logic [4:0]  rom_addr_t;
    typedef logic [7:0]  apb_addr_t;

    // counter widths
    typedef logic [7:0]  delay_cnt_t;
    typedef logic [7:0]  fill_cnt_t;
    typedef logic [1:0]  wr_cnt_t;

    // one word on its way to the writer
    typedef struct packed {
        logic      rs;          // 0 command, 1 data
        lcd_data_t data;
    } lcd_word_t;

    typedef struct packed {
        logic      rs;
        logic      wait_after;  // settle after this word
        lcd_data_t data;
    } rom_entry_t;

    // panel pins
    typedef struct packed {
        logic      cs_n;
        logic      rs;
        logic      wr_n;
        lcd_data_t db;
    } lcd_bus_t;

    localparam int INIT_ROM_DEPTH    = 18;
    localparam int INIT_DELAY_CYCLES = 200;    // scaled down for sim
    localparam int FILL_WORDS        = 128;    // 16 x 8 window
    localparam lcd_data_t FILL_COLOR = 16'hFFFF;

    // strobe shape
    localparam int WR_LOW_CYCLES  = 2;
    localparam int WR_HIGH_CYCLES = 2;

    // apb register map
    localparam apb_addr_t REG_CMD    = 8'h00;  // write only
    localparam apb_addr_t REG_DATA   = 8'h04;  // write only
    localparam apb_addr_t REG_STATUS = 8'h08;  // read only

    localparam int STAT_INIT_DONE_BIT = 0;
    localparam int STAT_SLOT_FULL_BIT = 1;

endpackage
